//--- rtl/vdp_consts.svh
//**************************************************************************
// sizing constants for the register access path
// the copper list depth must stay a power of two, the walker relies on it
//**************************************************************************

`ifndef VDP_CONSTS_SVH
`define VDP_CONSTS_SVH

// register file
`define VDP_REG_COUNT 32
`define VDP_ADDR_W 5
`define VDP_DATA_W 16

// raster line counter
`define VDP_LINE_W 9

// copper command list
`define VDP_COP_DEPTH 16
`define VDP_COP_IDX_W 4

`endif

//--- rtl/vdp_pkg.sv
//**************************************************************************
// shared types of the register access path
// widths come from the constants header, the copper entry is 31 bits
//**************************************************************************

`include "vdp_consts.svh"

package vdp_pkg;

    // register address, one of 32
    typedef logic [`VDP_ADDR_W-1:0] reg_addr_t;

    // register value
    typedef logic [`VDP_DATA_W-1:0] reg_data_t;

    // raster line number
    typedef logic [`VDP_LINE_W-1:0] line_t;

    // one copper command
    // written once the raster reaches trigger_line, last ends the list
    typedef struct packed {
        line_t     trigger_line;
        reg_addr_t address;
        reg_data_t data;
        logic      last;
    } cop_entry_t;

endpackage

//--- rtl/vdp_reg_bus_if.sv
//**************************************************************************
// register bus between host interface and register file
// one write port, one read port with combinational read data
//**************************************************************************

`timescale 1ns/1ps

interface vdp_reg_bus_if;

    logic               write_en;
    vdp_pkg::reg_addr_t write_address;
    vdp_pkg::reg_data_t write_data;
    vdp_pkg::reg_addr_t read_address;
    vdp_pkg::reg_data_t read_data;

    modport host_side (
        output write_en, write_address, write_data, read_address,
        input  read_data
    );

    modport reg_side (
        input  write_en, write_address, write_data, read_address,
        output read_data
    );

endinterface

//--- rtl/vdp_host_interface.sv
//**************************************************************************
// merges CPU and copper writes onto the register bus, CPU has priority
// host strobes are levels, only the first cycle of a write level counts
// the top bit of host_address is ignored
//**************************************************************************

`timescale 1ns/1ps

`include "vdp_consts.svh"

module vdp_host_interface (
    input  logic                clk,
    input  logic                reset,

    // CPU side
    input  logic [`VDP_ADDR_W:0] host_address,
    input  logic                host_write_en,
    input  logic                host_read_en,
    input  vdp_pkg::reg_data_t  host_write_data,
    output logic                ready,
    output vdp_pkg::reg_data_t  host_read_data,

    // copper side
    input  logic                cop_write_en,
    input  vdp_pkg::reg_addr_t  cop_write_address,
    input  vdp_pkg::reg_data_t  cop_write_data,
    output logic                cop_accept,

    vdp_reg_bus_if.host_side    bus
);

    logic host_write_en_r;
    logic host_read_en_r;
    logic host_write_new;
    logic host_read_new;
    logic strobe_r;

    // write stage between arbitration and the bus
    logic               pend_valid;
    vdp_pkg::reg_addr_t pend_address;
    vdp_pkg::reg_data_t pend_data;

    vdp_pkg::reg_addr_t read_address_r;

    // rising edge of the strobe levels
    assign host_write_new = host_write_en && !host_write_en_r;
    assign host_read_new  = host_read_en && !host_read_en_r;

    // a new CPU write blocks the copper for this cycle, it keeps its request
    assign cop_accept = cop_write_en && !host_write_new;

    // reads are always free, data comes straight from the register file
    assign host_read_data = bus.read_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            host_write_en_r <= 1'b0;
            host_read_en_r  <= 1'b0;
            strobe_r        <= 1'b0;
            ready           <= 1'b0;
            pend_valid      <= 1'b0;
            bus.write_en    <= 1'b0;
        end else begin
            host_write_en_r <= host_write_en;
            host_read_en_r  <= host_read_en;

            // ready one cycle after the strobe was registered
            strobe_r <= host_write_new || host_read_new;
            ready    <= strobe_r;

            pend_valid   <= host_write_new || cop_accept;
            bus.write_en <= pend_valid;
        end
    end

    // winning address and data, CPU first
    always_ff @(posedge clk) begin
        if (host_write_new) begin
            pend_address <= host_address[`VDP_ADDR_W-1:0];
            pend_data    <= host_write_data;
        end else if (cop_accept) begin
            pend_address <= cop_write_address;
            pend_data    <= cop_write_data;
        end

        bus.write_address <= pend_address;
        bus.write_data    <= pend_data;
    end

    // read address, second stage lines up with ready
    always_ff @(posedge clk) begin
        if (host_read_new) begin
            read_address_r <= host_address[`VDP_ADDR_W-1:0];
        end
        bus.read_address <= read_address_r;
    end

    // a new CPU write is never shared with the copper and reaches the bus two cycles on
    a_host_write_first: assert property (@(posedge clk) disable iff (reset)
        host_write_new |-> !cop_accept ##2
            (bus.write_en && bus.write_data == $past(host_write_data, 2)))
        else $error("host write lost or shared with copper");

    // every strobe gets its ready pulse
    a_ready_follows: assert property (@(posedge clk) disable iff (reset)
        (host_write_new || host_read_new) |-> ##2 ready)
        else $error("ready missing after host strobe");

endmodule

//--- rtl/vdp_copper.sv
//**************************************************************************
// copper: raster-timed command list that issues register writes
// load the list only while cop_enable is low
// the walk stops after the last flag or after the final list entry
//**************************************************************************

`timescale 1ns/1ps

`include "vdp_consts.svh"

module vdp_copper (
    input  logic                     clk,
    input  logic                     reset,

    // raster and control
    input  logic                     cop_enable,
    input  logic                     frame_start,
    input  logic                     line_start,

    // list load port
    input  logic                     cop_load_en,
    input  logic [`VDP_COP_IDX_W-1:0] cop_load_index,
    input  vdp_pkg::cop_entry_t      cop_load_entry,

    // write request towards the host interface
    output logic                     cop_write_en,
    output vdp_pkg::reg_addr_t       cop_write_address,
    output vdp_pkg::reg_data_t       cop_write_data,
    input  logic                     cop_accept
);

    vdp_pkg::cop_entry_t cop_list [`VDP_COP_DEPTH];

    vdp_pkg::line_t               line_count;
    logic [`VDP_COP_IDX_W-1:0]    entry_ptr;
    logic                         running;
    vdp_pkg::cop_entry_t          cur_entry;
    logic                         entry_due;

    // command list memory
    always_ff @(posedge clk) begin
        if (cop_load_en) begin
            cop_list[cop_load_index] <= cop_load_entry;
        end
    end

    assign cur_entry = cop_list[entry_ptr];

    // raster reached the entry and no request is outstanding
    assign entry_due = running && cop_enable && !cop_write_en &&
                       (cur_entry.trigger_line <= line_count);

    // line counter, restarted each frame
    always_ff @(posedge clk) begin
        if (reset) begin
            line_count <= '0;
        end else if (frame_start) begin
            line_count <= '0;
        end else if (line_start) begin
            line_count <= line_count + 1'b1;
        end
    end

    // walker
    always_ff @(posedge clk) begin
        if (reset) begin
            running      <= 1'b0;
            entry_ptr    <= '0;
            cop_write_en <= 1'b0;
        end else if (frame_start) begin
            // an unaccepted request is dropped with the old frame
            running      <= cop_enable;
            entry_ptr    <= '0;
            cop_write_en <= 1'b0;
        end else if (cop_write_en) begin
            if (cop_accept) begin
                cop_write_en <= 1'b0;
                if (cur_entry.last || (&entry_ptr)) begin
                    running <= 1'b0;
                end else begin
                    entry_ptr <= entry_ptr + 1'b1;
                end
            end
        end else if (entry_due) begin
            cop_write_en <= 1'b1;
        end
    end

    // request payload, held while the request waits
    always_ff @(posedge clk) begin
        if (entry_due) begin
            cop_write_address <= cur_entry.address;
            cop_write_data    <= cur_entry.data;
        end
    end

    // the host interface may hold off the request, it must not change meanwhile
    a_request_held: assert property (@(posedge clk) disable iff (reset)
        (cop_write_en && !cop_accept && !frame_start) |=>
            (cop_write_en && $stable(cop_write_address) && $stable(cop_write_data)))
        else $error("copper request changed before accept");

endmodule

//--- rtl/vdp_register_file.sv
//**************************************************************************
// 32 x 16-bit display registers
// one synchronous write port, one combinational read port
//**************************************************************************

`timescale 1ns/1ps

`include "vdp_consts.svh"

module vdp_register_file (
    input  logic            clk,
    input  logic            reset,

    vdp_reg_bus_if.reg_side bus
);

    vdp_pkg::reg_data_t regs [`VDP_REG_COUNT];

    // all registers start from 0 so the display comes up blank
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `VDP_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (bus.write_en) begin
            regs[bus.write_address] <= bus.write_data;
        end
    end

    // read port, the address is already registered by the host interface
    assign bus.read_data = regs[bus.read_address];

endmodule

//--- rtl/vdp_register_top.sv
//**************************************************************************
// register access path top: host interface, copper and register file
// line_start and frame_start come from an external raster generator
//**************************************************************************

`timescale 1ns/1ps

`include "vdp_consts.svh"

module vdp_register_top (
    input  logic                      clk,
    input  logic                      reset,

    // CPU bus
    input  logic [`VDP_ADDR_W:0]       host_address,
    input  logic                      host_write_en,
    input  vdp_pkg::reg_data_t        host_write_data,
    input  logic                      host_read_en,
    output logic                      ready,
    output vdp_pkg::reg_data_t        host_read_data,

    // copper control and raster
    input  logic                      cop_enable,
    input  logic                      frame_start,
    input  logic                      line_start,

    // copper list load
    input  logic                      cop_load_en,
    input  logic [`VDP_COP_IDX_W-1:0] cop_load_index,
    input  vdp_pkg::line_t            cop_load_line,
    input  vdp_pkg::reg_addr_t        cop_load_address,
    input  vdp_pkg::reg_data_t        cop_load_data,
    input  logic                      cop_load_last
);

    vdp_reg_bus_if reg_bus ();

    vdp_pkg::cop_entry_t cop_load_entry;

    logic               cop_write_en;
    vdp_pkg::reg_addr_t cop_write_address;
    vdp_pkg::reg_data_t cop_write_data;
    logic               cop_accept;

    assign cop_load_entry = '{
        trigger_line: cop_load_line,
        address:      cop_load_address,
        data:         cop_load_data,
        last:         cop_load_last
    };

    vdp_host_interface host_interface_i (
        .clk               (clk),
        .reset             (reset),
        .host_address      (host_address),
        .host_write_en     (host_write_en),
        .host_read_en      (host_read_en),
        .host_write_data   (host_write_data),
        .ready             (ready),
        .host_read_data    (host_read_data),
        .cop_write_en      (cop_write_en),
        .cop_write_address (cop_write_address),
        .cop_write_data    (cop_write_data),
        .cop_accept        (cop_accept),
        .bus               (reg_bus.host_side)
    );

    vdp_copper copper_i (
        .clk               (clk),
        .reset             (reset),
        .cop_enable        (cop_enable),
        .frame_start       (frame_start),
        .line_start        (line_start),
        .cop_load_en       (cop_load_en),
        .cop_load_index    (cop_load_index),
        .cop_load_entry    (cop_load_entry),
        .cop_write_en      (cop_write_en),
        .cop_write_address (cop_write_address),
        .cop_write_data    (cop_write_data),
        .cop_accept        (cop_accept)
    );

    vdp_register_file register_file_i (
        .clk   (clk),
        .reset (reset),
        .bus   (reg_bus.reg_side)
    );

endmodule

//--- verif/vdp_register_tb.sv
//**************************************************************************
// testbench for the register access path with random stimulus from seed 3
// stops at the first mismatch and observes copper progress by hierarchy
//**************************************************************************

`timescale 1ns/1ps

`include "vdp_consts.svh"

module vdp_register_tb;

    localparam int WAIT_LIMIT = 64;

    logic                      clk;
    logic                      reset;
    logic [`VDP_ADDR_W:0]      host_address;
    logic                      host_write_en;
    vdp_pkg::reg_data_t        host_write_data;
    logic                      host_read_en;
    logic                      ready;
    vdp_pkg::reg_data_t        host_read_data;
    logic                      cop_enable;
    logic                      frame_start;
    logic                      line_start;
    logic                      cop_load_en;
    logic [`VDP_COP_IDX_W-1:0] cop_load_index;
    vdp_pkg::line_t            cop_load_line;
    vdp_pkg::reg_addr_t        cop_load_address;
    vdp_pkg::reg_data_t        cop_load_data;
    logic                      cop_load_last;

    // expected register contents
    vdp_pkg::reg_data_t model [`VDP_REG_COUNT];
    int                 error_count;

    vdp_register_top vdp_register_top_i (
        .clk              (clk),
        .reset            (reset),
        .host_address     (host_address),
        .host_write_en    (host_write_en),
        .host_write_data  (host_write_data),
        .host_read_en     (host_read_en),
        .ready            (ready),
        .host_read_data   (host_read_data),
        .cop_enable       (cop_enable),
        .frame_start      (frame_start),
        .line_start       (line_start),
        .cop_load_en      (cop_load_en),
        .cop_load_index   (cop_load_index),
        .cop_load_line    (cop_load_line),
        .cop_load_address (cop_load_address),
        .cop_load_data    (cop_load_data),
        .cop_load_last    (cop_load_last)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    task automatic stop_run();
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_data(input string test_name, input vdp_pkg::reg_data_t expected,
                              input vdp_pkg::reg_data_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("FAILED %s: expected %h, actual %h", test_name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_ready(input string test_name, input logic expected,
                               input logic actual);
        if (actual !== expected) begin
            error_count++;
            $display("FAILED %s: expected ready %b, actual %b", test_name, expected, actual);
            stop_run();
        end
    endtask

    function automatic vdp_pkg::reg_data_t random_data();
        logic [31:0] r;
        r = $urandom;
        return r[`VDP_DATA_W-1:0];
    endfunction

    // host address with a random top bit
    function automatic logic [`VDP_ADDR_W:0] random_address();
        logic [31:0] r;
        r = $urandom;
        return r[`VDP_ADDR_W:0];
    endfunction

    // inputs always change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // called one cycle after the strobe was driven and ends after the ready pulse
    task automatic wait_ready(input string test_name, output vdp_pkg::reg_data_t read_value);
        int cycles;
        cycles = 0;
        check_ready(test_name, 1'b0, ready);
        while (ready !== 1'b1 && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (ready !== 1'b1) begin
            $display("%s: ready never came after the host strobe", test_name);
            stop_run();
        end
        if (cycles != 1) begin
            $display("%s: ready came %0d cycles late instead of 1", test_name, cycles);
            stop_run();
        end
        read_value = host_read_data;
        next_cycle();
        check_ready(test_name, 1'b0, ready);
    endtask

    task automatic write_host(input string test_name, input logic [`VDP_ADDR_W:0] address,
                              input vdp_pkg::reg_data_t data);
        vdp_pkg::reg_data_t unused_data;
        host_address    = address;
        host_write_data = data;
        host_write_en   = 1'b1;
        next_cycle();
        host_write_en = 1'b0;
        wait_ready(test_name, unused_data);
        // top address bit is not decoded
        model[address[`VDP_ADDR_W-1:0]] = data;
    endtask

    task automatic read_and_check(input string test_name, input logic [`VDP_ADDR_W:0] address);
        vdp_pkg::reg_data_t data;
        host_address = address;
        host_read_en = 1'b1;
        next_cycle();
        host_read_en = 1'b0;
        wait_ready(test_name, data);
        check_data(test_name, model[address[`VDP_ADDR_W-1:0]], data);
    endtask

    task automatic check_all(input string test_name);
        logic [`VDP_ADDR_W:0] address;
        for (int i = 0; i < `VDP_REG_COUNT; i++) begin
            address = random_address();
            address[`VDP_ADDR_W-1:0] = i[`VDP_ADDR_W-1:0];
            read_and_check(test_name, address);
        end
    endtask

    // only the first cycle of a long write level may land
    task automatic hold_write(input string test_name);
        logic [`VDP_ADDR_W:0] address;
        vdp_pkg::reg_data_t   first_data;
        int                   ready_pulses;
        address      = random_address();
        first_data   = random_data();
        ready_pulses = 0;
        host_address    = address;
        host_write_data = first_data;
        host_write_en   = 1'b1;
        for (int i = 0; i < 5; i++) begin
            next_cycle();
            host_write_data = random_data();
            if (ready === 1'b1) begin
                ready_pulses++;
            end
        end
        host_write_en = 1'b0;
        repeat (3) begin
            next_cycle();
            if (ready === 1'b1) begin
                ready_pulses++;
            end
        end
        if (ready_pulses != 1) begin
            $display("%s: %0d ready pulses for one held write", test_name, ready_pulses);
            stop_run();
        end
        model[address[`VDP_ADDR_W-1:0]] = first_data;
        read_and_check(test_name, address);
    endtask

    task automatic load_entry(input int index, input vdp_pkg::line_t line,
                              input vdp_pkg::reg_addr_t address,
                              input vdp_pkg::reg_data_t data, input logic last);
        cop_load_en      = 1'b1;
        cop_load_index   = index[`VDP_COP_IDX_W-1:0];
        cop_load_line    = line;
        cop_load_address = address;
        cop_load_data    = data;
        cop_load_last    = last;
        next_cycle();
        cop_load_en = 1'b0;
    endtask

    task automatic start_frame(input logic enable);
        cop_enable  = enable;
        frame_start = 1'b1;
        next_cycle();
        frame_start = 1'b0;
    endtask

    task automatic pulse_line();
        line_start = 1'b1;
        next_cycle();
        line_start = 1'b0;
    endtask

    task automatic wait_copper_idle(input string test_name);
        int cycles;
        cycles = 0;
        while ((vdp_register_top_i.copper_i.running === 1'b1 ||
                vdp_register_top_i.cop_write_en === 1'b1) && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (vdp_register_top_i.copper_i.running === 1'b1 ||
            vdp_register_top_i.cop_write_en === 1'b1) begin
            $display("%s: copper did not finish its list", test_name);
            stop_run();
        end
        // last accepted write still travels through the bus stages
        repeat (3) next_cycle();
    endtask

    task automatic run_copper_list(input string test_name);
        vdp_pkg::reg_addr_t address;
        vdp_pkg::reg_data_t data;
        int                 active;
        int                 line_now;
        int                 last_line;
        active    = $urandom_range(2, 8);
        line_now  = $urandom_range(0, 2);
        last_line = 0;
        for (int i = 0; i < `VDP_COP_DEPTH; i++) begin
            address = vdp_pkg::reg_addr_t'($urandom_range(0, `VDP_REG_COUNT - 1));
            data    = random_data();
            if (i < active) begin
                load_entry(i, vdp_pkg::line_t'(line_now), address, data, i == active - 1);
                model[address] = data;
                last_line = line_now;
                line_now  = line_now + $urandom_range(1, 3);
            end else begin
                // line 0 would fire at once if the walk went past the last flag
                load_entry(i, '0, address, data, 1'b0);
            end
        end
        start_frame(1'b1);
        for (int l = 0; l < last_line + 2; l++) begin
            pulse_line();
            next_cycle();
        end
        wait_copper_idle(test_name);
        cop_enable = 1'b0;
        check_all(test_name);
    endtask

    // host write lands in the cycle the copper request is waiting
    task automatic collide_with_copper(input string test_name, input logic same_address);
        logic [`VDP_ADDR_W:0] host_addr;
        vdp_pkg::reg_addr_t   cop_addr;
        vdp_pkg::reg_data_t   host_data;
        vdp_pkg::reg_data_t   cop_data;
        vdp_pkg::reg_data_t   unused_data;
        int                   cycles;
        host_addr = random_address();
        host_data = random_data();
        cop_data  = random_data();
        cop_addr  = host_addr[`VDP_ADDR_W-1:0];
        if (!same_address) begin
            cop_addr = cop_addr + vdp_pkg::reg_addr_t'($urandom_range(1, `VDP_REG_COUNT - 1));
        end
        load_entry(0, vdp_pkg::line_t'(1), cop_addr, cop_data, 1'b1);
        start_frame(1'b1);
        // line 0 lies before the entry's trigger line
        next_cycle();
        if (vdp_register_top_i.cop_write_en !== 1'b0) begin
            $display("%s: copper fired before its trigger line", test_name);
            stop_run();
        end
        pulse_line();
        cycles = 0;
        while (vdp_register_top_i.cop_write_en !== 1'b1 && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (vdp_register_top_i.cop_write_en !== 1'b1) begin
            $display("%s: copper request never appeared", test_name);
            stop_run();
        end
        host_address    = host_addr;
        host_write_data = host_data;
        host_write_en   = 1'b1;
        next_cycle();
        host_write_en = 1'b0;
        if (vdp_register_top_i.cop_write_en !== 1'b1) begin
            $display("%s: copper request was not held behind the host write", test_name);
            stop_run();
        end
        wait_ready(test_name, unused_data);
        // host write lands before the copper write
        model[host_addr[`VDP_ADDR_W-1:0]] = host_data;
        model[cop_addr] = cop_data;
        wait_copper_idle(test_name);
        cop_enable = 1'b0;
        read_and_check(test_name, host_addr);
        read_and_check(test_name, {1'b0, cop_addr});
    endtask

    task automatic disabled_frame(input string test_name);
        for (int i = 0; i < 4; i++) begin
            load_entry(i, '0, vdp_pkg::reg_addr_t'($urandom_range(0, `VDP_REG_COUNT - 1)),
                       random_data(), i == 3);
        end
        start_frame(1'b0);
        // enable raised inside the frame must not start the walk
        cop_enable = 1'b1;
        for (int i = 0; i < 4; i++) begin
            pulse_line();
            next_cycle();
        end
        repeat (4) next_cycle();
        cop_enable = 1'b0;
        check_all(test_name);
    endtask

    initial begin
        error_count      = 0;
        void'($urandom(3));
        reset            = 1'b1;
        host_address     = '0;
        host_write_en    = 1'b0;
        host_write_data  = '0;
        host_read_en     = 1'b0;
        cop_enable       = 1'b0;
        frame_start      = 1'b0;
        line_start       = 1'b0;
        cop_load_en      = 1'b0;
        cop_load_index   = '0;
        cop_load_line    = '0;
        cop_load_address = '0;
        cop_load_data    = '0;
        cop_load_last    = 1'b0;
        for (int i = 0; i < `VDP_REG_COUNT; i++) begin
            model[i] = '0;
        end
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        next_cycle();

        check_all("reset values");
        for (int i = 0; i < 48; i++) begin
            write_host("random writes", random_address(), random_data());
            read_and_check("random writes", random_address());
        end
        check_all("random writes");
        for (int i = 0; i < 4; i++) begin
            hold_write("held write strobe");
        end
        for (int i = 0; i < 3; i++) begin
            run_copper_list("copper list");
        end
        collide_with_copper("same address collision", 1'b1);
        collide_with_copper("split address collision", 1'b0);
        disabled_frame("copper disabled");

        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+rtl
rtl/vdp_pkg.sv
rtl/vdp_reg_bus_if.sv
rtl/vdp_host_interface.sv
rtl/vdp_copper.sv
rtl/vdp_register_file.sv
rtl/vdp_register_top.sv
verif/vdp_register_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the register access path testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -f files.f --top-module vdp_register_tb \
    -o vdp_register_sim > "$LOG" 2>&1 \
    && ./obj_dir/vdp_register_sim >> "$LOG" 2>&1 \
    || echo "CHECKS FAILED" >> "$LOG"

grep -q "CHECKS FAILED" "$LOG" && { echo "simulation failed, see $LOG"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
